//--- design/sifhPkg.sv
package sifhPkg;

    localparam int NP        = 12;  // sample width
    localparam int NB        = 4;   // bin address width
    localparam int PIXEL_NUM = 4;
    localparam int DATA_NUM  = 8;   // samples per pixel per acquisition
    localparam int ACQ_NUM   = 2;   // acquisitions per pass
    localparam int COUNT_W   = 5;   // holds ACQ_NUM*DATA_NUM
    localparam int PIXEL_W   = 2;
    localparam int BIN_TOTAL = PIXEL_NUM * (2 ** NB);
    localparam int DATA_W    = $clog2(DATA_NUM);
    localparam int ACQ_W     = (ACQ_NUM > 1) ? $clog2(ACQ_NUM) : 1;
    localparam int FINE_SHIFT = NP - NB;  // coarse bin width in LSB bits

    typedef logic [NP-1:0]          sampleT;
    typedef logic [NB-1:0]          binT;
    typedef logic [PIXEL_W-1:0]     pixelT;
    typedef logic [COUNT_W-1:0]     countT;
    typedef logic [PIXEL_W+NB-1:0]  memAddrT;  // {pixel, bin}

    // fine window starts at middle of coarse bin minus half a window
    localparam sampleT WIN_OFFSET = sampleT'(2 ** (FINE_SHIFT - 1) - 2 ** (NB - 1));
    localparam sampleT WIN_SIZE   = sampleT'(2 ** NB);

    typedef enum logic {COARSE, FINE} phaseT;
    typedef enum logic {TRACK, READOUT} trackStateT;

    typedef struct packed {
        pixelT  pixel;
        phaseT  phase;
        logic   lastOfPhase;
        sampleT sample;
    } sampleInfoT;

    typedef struct packed {
        pixelT pixel;
        binT   bin;
        phaseT phase;
        logic  lastOfPhase;
        logic  inWindow;
    } binReqT;

    typedef struct packed {
        pixelT pixel;
        binT   bin;
        countT count;
        phaseT phase;
        logic  lastOfPhase;
        logic  counted;  // bin was incremented
    } binCountT;

    typedef struct packed {
        pixelT pixel;
        binT   coarseBin;
        binT   fineBin;
        countT fineCount;
    } peakResultT;

endpackage

//--- design/sampleSequencer.sv
`timescale 1ns/1ps

module sampleSequencer (
    input  logic                clk,
    input  logic                combin_res,
    input  logic                sampleValid,
    input  sifhPkg::sampleT     sample,
    input  logic                phaseDone,
    output logic                busy,
    output sifhPkg::sampleInfoT sampleInfo,
    output logic                accept
);

    logic [sifhPkg::DATA_W-1:0] dataCnt;   // sample within pixel
    sifhPkg::pixelT             pixelCnt;
    logic [sifhPkg::ACQ_W-1:0]  acqCnt;
    sifhPkg::phaseT             phase;

    logic dataLast;
    logic pixelLast;
    logic acqLast;
    logic lastOfPhase;

    assign accept = sampleValid && !busy;  // strobes during busy are lost

    assign dataLast    = (dataCnt == (sifhPkg::DATA_W)'(sifhPkg::DATA_NUM - 1));
    assign pixelLast   = (pixelCnt == sifhPkg::pixelT'(sifhPkg::PIXEL_NUM - 1));
    assign acqLast     = (acqCnt == (sifhPkg::ACQ_W)'(sifhPkg::ACQ_NUM - 1));
    assign lastOfPhase = dataLast && pixelLast && acqLast;

    always_comb begin
        sampleInfo.pixel       = pixelCnt;
        sampleInfo.phase       = phase;
        sampleInfo.lastOfPhase = lastOfPhase;
        sampleInfo.sample      = sample;
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            dataCnt  <= '0;
            pixelCnt <= '0;
            acqCnt   <= '0;
            phase    <= sifhPkg::COARSE;
            busy     <= 1'b0;
        end else if (phaseDone) begin
            // tracker finished the pass, swap histogram type
            busy     <= 1'b0;
            phase    <= (phase == sifhPkg::COARSE) ? sifhPkg::FINE : sifhPkg::COARSE;
            dataCnt  <= '0;
            pixelCnt <= '0;
            acqCnt   <= '0;
        end else if (accept) begin
            if (lastOfPhase) begin
                busy <= 1'b1;  // hold off input until tracker is done
            end
            if (dataLast) begin
                dataCnt <= '0;
                if (pixelLast) begin
                    pixelCnt <= '0;
                    if (acqLast) begin
                        acqCnt <= '0;
                    end else begin
                        acqCnt <= acqCnt + 1'b1;
                    end
                end else begin
                    pixelCnt <= pixelCnt + 1'b1;
                end
            end else begin
                dataCnt <= dataCnt + 1'b1;
            end
        end
    end

endmodule

//--- design/binMapper.sv
`timescale 1ns/1ps

module binMapper (
    input  sifhPkg::sampleInfoT                   sampleInfo,
    input  sifhPkg::binT [sifhPkg::PIXEL_NUM-1:0] coarsePeaks,
    output sifhPkg::binReqT                       binReq
);

    sifhPkg::binT    peakBin;
    sifhPkg::sampleT lowerBound;
    sifhPkg::sampleT upperBound;  // exclusive
    sifhPkg::sampleT offset;

    // window position from this pixel's coarse peak
    always_comb begin
        peakBin    = coarsePeaks[sampleInfo.pixel];
        lowerBound = {peakBin, {sifhPkg::FINE_SHIFT{1'b0}}} + sifhPkg::WIN_OFFSET;
        upperBound = lowerBound + sifhPkg::WIN_SIZE;
        offset     = sampleInfo.sample - lowerBound;
    end

    always_comb begin
        binReq.pixel       = sampleInfo.pixel;
        binReq.phase       = sampleInfo.phase;
        binReq.lastOfPhase = sampleInfo.lastOfPhase;
        if (sampleInfo.phase == sifhPkg::COARSE) begin
            binReq.bin      = sampleInfo.sample[sifhPkg::NP-1 -: sifhPkg::NB];  // top bits
            binReq.inWindow = 1'b1;
        end else begin
            binReq.bin      = offset[sifhPkg::NB-1:0];  // one LSB per bin
            binReq.inWindow = (sampleInfo.sample >= lowerBound) &&
                              (sampleInfo.sample < upperBound);
        end
    end

endmodule

//--- design/binCounterRam.sv
`timescale 1ns/1ps

module binCounterRam (
    input  logic              clk,
    input  logic              combin_res,
    input  logic              accept,
    input  sifhPkg::binReqT   binReq,
    output sifhPkg::binCountT binCount,
    output logic              countValid
);

    sifhPkg::countT                countMem [sifhPkg::BIN_TOTAL];
    logic [sifhPkg::BIN_TOTAL-1:0] binValid;  // bin holds a count from this pass

    sifhPkg::memAddrT addr;
    sifhPkg::countT   newCount;
    logic             doWrite;

    assign addr    = {binReq.pixel, binReq.bin};
    assign doWrite = accept && binReq.inWindow;

    // stale counts are ignored, first hit of a pass stores one
    assign newCount = binValid[addr] ? sifhPkg::countT'(countMem[addr] + 1'b1)
                                     : sifhPkg::countT'(1);

    always_ff @(posedge clk) begin
        if (doWrite) begin
            countMem[addr] <= newCount;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= '0;
        end else if (accept) begin
            if (binReq.inWindow) begin
                binValid[addr] <= 1'b1;
            end
            if (binReq.lastOfPhase) begin
                binValid <= '0;  // whole histogram empty for next pass
            end
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            countValid <= 1'b0;
        end else begin
            countValid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            binCount.pixel       <= binReq.pixel;
            binCount.bin         <= binReq.bin;
            binCount.count       <= binReq.inWindow ? newCount : '0;
            binCount.phase       <= binReq.phase;
            binCount.lastOfPhase <= binReq.lastOfPhase;
            binCount.counted     <= binReq.inWindow;
        end
    end

endmodule

//--- design/peakTracker.sv
`timescale 1ns/1ps

module peakTracker (
    input  logic                                  clk,
    input  logic                                  combin_res,
    input  logic                                  countValid,
    input  sifhPkg::binCountT                     binCount,
    output sifhPkg::binT [sifhPkg::PIXEL_NUM-1:0] coarsePeaks,
    output logic                                  phaseDone,
    output logic                                  resultValid,
    output sifhPkg::peakResultT                   result
);

    sifhPkg::countT      maxCount [sifhPkg::PIXEL_NUM];
    sifhPkg::binT        maxBin   [sifhPkg::PIXEL_NUM];
    sifhPkg::countT      updCount [sifhPkg::PIXEL_NUM];  // maxima incl. this entry
    sifhPkg::binT        updBin   [sifhPkg::PIXEL_NUM];
    sifhPkg::trackStateT state;
    sifhPkg::pixelT      readPixel;
    logic                isNewMax;
    logic                passEnd;

    // strict compare, so on ties the earlier bin is kept
    always_comb begin
        isNewMax = countValid && binCount.counted &&
                   (binCount.count > maxCount[binCount.pixel]);
        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
            updCount[p] = maxCount[p];
            updBin[p]   = maxBin[p];
        end
        if (isNewMax) begin
            updCount[binCount.pixel] = binCount.count;
            updBin[binCount.pixel]   = binCount.bin;
        end
    end

    assign passEnd = countValid && binCount.lastOfPhase;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
                maxCount[p]    <= '0;
                maxBin[p]      <= '0;
                coarsePeaks[p] <= '0;
            end
            state       <= sifhPkg::TRACK;
            readPixel   <= '0;
            phaseDone   <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            phaseDone   <= 1'b0;
            resultValid <= 1'b0;
            case (state)
                sifhPkg::TRACK: begin
                    for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
                        maxCount[p] <= updCount[p];
                        maxBin[p]   <= updBin[p];
                    end
                    if (passEnd && binCount.phase == sifhPkg::COARSE) begin
                        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
                            coarsePeaks[p] <= updBin[p];  // window centres for fine pass
                            maxCount[p]    <= '0;
                            maxBin[p]      <= '0;
                        end
                        phaseDone <= 1'b1;
                    end else if (passEnd) begin
                        state     <= sifhPkg::READOUT;
                        readPixel <= '0;
                    end
                end
                sifhPkg::READOUT: begin
                    resultValid <= 1'b1;
                    readPixel   <= readPixel + 1'b1;
                    if (readPixel == sifhPkg::pixelT'(sifhPkg::PIXEL_NUM - 1)) begin
                        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
                            maxCount[p] <= '0;
                            maxBin[p]   <= '0;
                        end
                        readPixel <= '0;
                        phaseDone <= 1'b1;
                        state     <= sifhPkg::TRACK;
                    end
                end
                default: state <= sifhPkg::TRACK;
            endcase
        end
    end

    // record for the pixel being read out, empty pixel gives bin 0 count 0
    always_ff @(posedge clk) begin
        if (state == sifhPkg::READOUT) begin
            result.pixel     <= readPixel;
            result.coarseBin <= coarsePeaks[readPixel];
            result.fineBin   <= maxBin[readPixel];
            result.fineCount <= maxCount[readPixel];
        end
    end

endmodule

//--- design/histogramTop.sv
`timescale 1ns/1ps

module histogramTop (
    input  logic                clk,
    input  logic                combin_res,
    input  logic                sampleValid,
    input  sifhPkg::sampleT     sample,
    output logic                busy,
    output logic                resultValid,
    output sifhPkg::peakResultT result
);

    sifhPkg::sampleInfoT                   sampleInfo;
    sifhPkg::binReqT                       binReq;
    sifhPkg::binCountT                     binCount;
    sifhPkg::binT [sifhPkg::PIXEL_NUM-1:0] coarsePeaks;  // per-pixel fine window centre
    logic                                  accept;
    logic                                  countValid;
    logic                                  phaseDone;

    sampleSequencer sampleSequencer0 (
        .clk         (clk),
        .combin_res  (combin_res),
        .sampleValid (sampleValid),
        .sample      (sample),
        .phaseDone   (phaseDone),
        .busy        (busy),
        .sampleInfo  (sampleInfo),
        .accept      (accept)
    );

    binMapper binMapper0 (
        .sampleInfo  (sampleInfo),
        .coarsePeaks (coarsePeaks),
        .binReq      (binReq)
    );

    binCounterRam binCounterRam0 (
        .clk         (clk),
        .combin_res  (combin_res),
        .accept      (accept),
        .binReq      (binReq),
        .binCount    (binCount),
        .countValid  (countValid)
    );

    peakTracker peakTracker0 (
        .clk         (clk),
        .combin_res  (combin_res),
        .countValid  (countValid),
        .binCount    (binCount),
        .coarsePeaks (coarsePeaks),
        .phaseDone   (phaseDone),
        .resultValid (resultValid),
        .result      (result)
    );

endmodule

//--- verif/histogramModel.svh
    // per-pixel samples of the current round, slot is acquisition * DATA_NUM + sample
    sifhPkg::sampleT     coarseSamples [sifhPkg::PIXEL_NUM][sifhPkg::ACQ_NUM*sifhPkg::DATA_NUM];
    sifhPkg::sampleT     fineSamples   [sifhPkg::PIXEL_NUM][sifhPkg::ACQ_NUM*sifhPkg::DATA_NUM];
    sifhPkg::peakResultT expected      [sifhPkg::PIXEL_NUM];

    // k is the position of the accepted sample within its pass
    function automatic void recordSample(input bit finePass, input int k, input sifhPkg::sampleT v);
        int p;
        int slot;
        p    = (k / sifhPkg::DATA_NUM) % sifhPkg::PIXEL_NUM;
        slot = (k / (sifhPkg::DATA_NUM * sifhPkg::PIXEL_NUM)) * sifhPkg::DATA_NUM
               + k % sifhPkg::DATA_NUM;
        if (finePass) fineSamples[p][slot] = v;
        else coarseSamples[p][slot] = v;
    endfunction

    // running maximum in arrival order, a later bin only wins with a higher count
    function automatic void histogramPeak(input bit finePass, input int p, input int lower,
                                          output sifhPkg::binT peakBin, output int peakCount);
        int hist [2**sifhPkg::NB];
        int s;
        int bin;
        peakBin   = '0;
        peakCount = 0;
        for (int b = 0; b < 2**sifhPkg::NB; b++) begin
            hist[b] = 0;
        end
        for (int i = 0; i < sifhPkg::ACQ_NUM * sifhPkg::DATA_NUM; i++) begin
            s = finePass ? fineSamples[p][i] : coarseSamples[p][i];
            if (!finePass) begin
                bin = s >> (sifhPkg::NP - sifhPkg::NB);  // top bits
            end else if (s >= lower && s < lower + 2**sifhPkg::NB) begin
                bin = s - lower;
            end else begin
                bin = -1;  // outside the fine window
            end
            if (bin >= 0) begin
                hist[bin]++;
                if (hist[bin] > peakCount) begin
                    peakCount = hist[bin];
                    peakBin   = sifhPkg::binT'(bin);
                end
            end
        end
    endfunction

    function automatic void predictRecords();
        sifhPkg::binT coarseBin;
        sifhPkg::binT fineBin;
        int           count;
        int           lower;
        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
            histogramPeak(1'b0, p, 0, coarseBin, count);
            // window of 2^NB LSBs around the middle of the coarse peak bin
            lower = coarseBin * 2**(sifhPkg::NP - sifhPkg::NB)
                    + 2**(sifhPkg::NP - sifhPkg::NB - 1) - 2**(sifhPkg::NB - 1);
            histogramPeak(1'b1, p, lower, fineBin, count);
            expected[p].pixel     = sifhPkg::pixelT'(p);
            expected[p].coarseBin = coarseBin;
            expected[p].fineBin   = fineBin;
            expected[p].fineCount = sifhPkg::countT'(count);
        end
    endfunction

//--- verif/histogramTb.sv
`timescale 1ns/1ps

module histogramTb;

    logic                clk;
    logic                combin_res;
    logic                sampleValid;
    sifhPkg::sampleT     sample;
    logic                busy;
    logic                resultValid;
    sifhPkg::peakResultT result;

    integer              seed;
    int                  errors;
    int                  errorsAtStart;
    int                  checks;
    int                  testsRun;
    int                  failedTests;
    int                  centre   [sifhPkg::PIXEL_NUM];
    sifhPkg::peakResultT received [sifhPkg::PIXEL_NUM];

    `include "histogramModel.svh"

    histogramTop dut0 (
        .clk         (clk),
        .combin_res  (combin_res),
        .sampleValid (sampleValid),
        .sample      (sample),
        .busy        (busy),
        .resultValid (resultValid),
        .result      (result)
    );

    always #5 clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        checks++;
        if (expVal !== actVal) begin
            errors++;
            $display("Error at time %0t: %s expected %0d got %0d", $time, name, expVal, actVal);
        end
    endtask

    task automatic abortRun(input string what);
        $display("Timeout at time %0t while waiting for %s", $time, what);
        $display("Test failed");
        $finish;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            sampleValid <= 1'b0;
        end
    endtask

    // busySeen is the level the DUT sees on the edge that samples the strobe
    task automatic strobe(input sifhPkg::sampleT value, output logic busySeen);
        @(posedge clk);
        sampleValid <= 1'b1;
        sample      <= value;
        @(negedge clk);
        busySeen = busy;
    endtask

    task automatic waitIdle();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (busy) begin
            cycles++;
            if (cycles > 200) abortRun("busy to fall");
            @(negedge clk);
        end
    endtask

    function automatic sifhPkg::sampleT makeSample(input int p, input bit far);
        int v;
        if (!far && ($random(seed) & 7) == 0) begin
            v = $random(seed) & (2**sifhPkg::NP - 1);  // background hit anywhere
        end else begin
            v = far ? (centre[p] + 2**(sifhPkg::NP - 1)) % 2**sifhPkg::NP : centre[p];
            v = v + $random(seed) % 13;  // jitter -12..12
        end
        if (v < 0) v = 0;
        if (v > 2**sifhPkg::NP - 1) v = 2**sifhPkg::NP - 1;
        return sifhPkg::sampleT'(v);
    endfunction

    task automatic newCentres();
        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
            // near the middle of a random coarse bin
            centre[p] = (($random(seed) & 15) << 8) + 112 + ($random(seed) & 31);
        end
    endtask

    task automatic sendPass(input bit finePass, input int count, input int farPixel);
        logic            busySeen;
        int              p;
        sifhPkg::sampleT v;
        for (int k = 0; k < count; k++) begin
            if (($random(seed) & 3) == 0) idle(1 + ($random(seed) & 3));  // random gap
            p = (k / sifhPkg::DATA_NUM) % sifhPkg::PIXEL_NUM;
            v = makeSample(p, finePass && p == farPixel);
            strobe(v, busySeen);
            checkValue("busy while sending a pass sample", 0, busySeen);
            recordSample(finePass, k, v);
        end
    endtask

    // stray strobes behind the closing sample must be dropped
    task automatic endPass(input int strays);
        logic busySeen;
        if (strays == 0) begin
            idle(1);
            @(negedge clk);
            busySeen = busy;
        end else begin
            strobe(sifhPkg::sampleT'($random(seed)), busySeen);
        end
        checkValue("busy after closing sample", 1, busySeen);
        for (int i = 1; i < strays; i++) begin
            strobe(sifhPkg::sampleT'($random(seed)), busySeen);
            checkValue("busy under stray strobe", 1, busySeen);
        end
        if (strays > 0) idle(1);
    endtask

    task automatic collectRecords();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!resultValid) begin
            cycles++;
            if (cycles > 50) abortRun("the first result record");
            @(negedge clk);
        end
        for (int i = 0; i < sifhPkg::PIXEL_NUM; i++) begin
            if (i > 0) @(negedge clk);  // records must be back to back
            received[i] = result;
            checkValue($sformatf("resultValid (record %0d)", i), 1, resultValid);
            checkValue($sformatf("result.pixel (record %0d)", i), expected[i].pixel, result.pixel);
            checkValue($sformatf("result.coarseBin (pixel %0d)", i),
                       expected[i].coarseBin, result.coarseBin);
            checkValue($sformatf("result.fineBin (pixel %0d)", i),
                       expected[i].fineBin, result.fineBin);
            checkValue($sformatf("result.fineCount (pixel %0d)", i),
                       expected[i].fineCount, result.fineCount);
        end
        @(negedge clk);
        checkValue("resultValid after last record", 0, resultValid);
    endtask

    task automatic runRound(input int farPixel, input int strays);
        int passLen;
        passLen = sifhPkg::PIXEL_NUM * sifhPkg::ACQ_NUM * sifhPkg::DATA_NUM;
        newCentres();
        waitIdle();
        sendPass(1'b0, passLen, -1);
        endPass(strays);
        waitIdle();
        sendPass(1'b1, passLen, farPixel);
        endPass(strays);
        predictRecords();
        collectRecords();
        waitIdle();
    endtask

    task automatic applyReset();
        @(posedge clk);
        combin_res  <= 1'b0;
        sampleValid <= 1'b0;
        repeat (4) @(posedge clk);
        combin_res <= 1'b1;
    endtask

    task automatic reportTest(input string name);
        testsRun++;
        if (errors == errorsAtStart) begin
            $display("%s: passed", name);
        end else begin
            failedTests++;
            $display("%s: %0d errors", name, errors - errorsAtStart);
        end
        errorsAtStart = errors;
    endtask

    initial begin
        clk           = 1'b0;
        combin_res    = 1'b0;
        sampleValid   = 1'b0;
        sample        = '0;
        seed          = 32'h586fea8c;
        errors        = 0;
        errorsAtStart = 0;
        checks        = 0;
        testsRun      = 0;
        failedTests   = 0;
        repeat (4) @(posedge clk);
        combin_res <= 1'b1;

        @(negedge clk);
        checkValue("busy after reset", 0, busy);
        checkValue("resultValid after reset", 0, resultValid);
        runRound(-1, 0);
        reportTest("test 1 reset state and record order");

        runRound(-1, 0);
        reportTest("test 2 coarse peak per pixel");

        runRound(2, 0);  // pixel 2 fine samples land half the range away
        checkValue("result.fineBin (far pixel 2)", 0, received[2].fineBin);
        checkValue("result.fineCount (far pixel 2)", 0, received[2].fineCount);
        reportTest("test 3 fine window and empty pixel");

        runRound(-1, 2);
        reportTest("test 4 strobes dropped while busy");

        for (int r = 0; r < 3; r++) begin
            runRound(-1, 0);
        end
        reportTest("test 5 three rounds with new centres");

        newCentres();
        waitIdle();
        sendPass(1'b0, sifhPkg::PIXEL_NUM * sifhPkg::ACQ_NUM * sifhPkg::DATA_NUM, -1);
        endPass(0);
        waitIdle();
        sendPass(1'b1, sifhPkg::PIXEL_NUM * sifhPkg::ACQ_NUM * sifhPkg::DATA_NUM, -1);
        endPass(0);
        applyReset();  // fine pass cut off while busy, before its records
        @(negedge clk);
        checkValue("busy after mid-pass reset", 0, busy);
        runRound(-1, 0);
        reportTest("test 6 reset in the middle of a pass");

        $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
                 testsRun, failedTests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+verif
design/sifhPkg.sv
design/sampleSequencer.sv
design/binMapper.sv
design/binCounterRam.sv
design/peakTracker.sv
design/histogramTop.sv
verif/histogramTb.sv
